// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= ** PASS **

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+hw
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/instrDecoder.sv
hw/waitTimer.sv
hw/mainFsm.sv
hw/controlRom.sv
hw/controlUnit.sv
tests/controlUnitTb.sv

// ==== hw/controlRom.sv ====
`include "ctrl_defines.svh"

module controlRom (
    input  ctrlPkg::stateCode_t stateCode,
    output logic [2:0]          aluOp,
    output logic [1:0]          aluSrcA,
    output logic [2:0]          aluSrcB,
    output logic [2:0]          pcSrc,
    output logic [1:0]          regDst,
    output logic [2:0]          memToReg,
    output logic                regWrite,
    output logic                pcWrite,
    output logic                irWrite,
    output logic                aWrite,
    output logic                bWrite,
    output logic                aluOutCtrl,
    output logic                resetOut
);

    localparam ctrlPkg::ctrlWord_t mPcWrite = ctrlPkg::ctrlWord_t'(1) << ctrlPkg::pcWriteBit;
    localparam ctrlPkg::ctrlWord_t mIrWrite = ctrlPkg::ctrlWord_t'(1) << ctrlPkg::irWriteBit;
    localparam ctrlPkg::ctrlWord_t mAWrite  = ctrlPkg::ctrlWord_t'(1) << ctrlPkg::aWriteBit;
    localparam ctrlPkg::ctrlWord_t mBWrite  = ctrlPkg::ctrlWord_t'(1) << ctrlPkg::bWriteBit;
    localparam ctrlPkg::ctrlWord_t mAluOut  = ctrlPkg::ctrlWord_t'(1) << ctrlPkg::aluOutBit;
    localparam ctrlPkg::ctrlWord_t mReset   = ctrlPkg::ctrlWord_t'(1) << ctrlPkg::resetOutBit;

    ctrlPkg::ctrlWord_t word;

    // ALU operation with its two operands
    function automatic ctrlPkg::ctrlWord_t aluWord(input logic [2:0] op,
                                                   input logic [1:0] srcA,
                                                   input logic [2:0] srcB);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w[ctrlPkg::aluOpLsb +: 3]   = op;
        w[ctrlPkg::aluSrcALsb +: 2] = srcA;
        w[ctrlPkg::aluSrcBLsb +: 3] = srcB;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t pcSel(input logic [2:0] sel);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w[ctrlPkg::pcSrcLsb +: 3] = sel;
        return w;
    endfunction

    // Register file write with destination and data select
    function automatic ctrlPkg::ctrlWord_t wb(input logic [1:0] dst, input logic [2:0] m2r);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w[ctrlPkg::regDstLsb +: 2]   = dst;
        w[ctrlPkg::memToRegLsb +: 3] = m2r;
        w[ctrlPkg::regWriteBit]      = 1'b1;
        return w;
    endfunction

    always_comb begin
        case (stateCode)
            // Stack pointer preset
            `ST_RESET:     word = wb(`DST_SP, `M2R_SPINIT) | mReset;
            // PC + 4 while memory answers
            `ST_FETCH0:    word = aluWord(`ALU_ADD, `SRCA_PC, `SRCB_FOUR) | pcSel(`PCSRC_ALU);
            `ST_FETCH1:    word = aluWord(`ALU_ADD, `SRCA_PC, `SRCB_FOUR) | pcSel(`PCSRC_ALU)
                                  | mPcWrite | mIrWrite;
            // Branch target precomputed into ALUout
            `ST_DECODE0:   word = aluWord(`ALU_ADD, `SRCA_PC, `SRCB_IMM);
            `ST_DECODE1:   word = aluWord(`ALU_ADD, `SRCA_PC, `SRCB_IMM)
                                  | mAWrite | mBWrite | mAluOut;
            `ST_ADD0:      word = aluWord(`ALU_ADD, `SRCA_A, `SRCB_B);
            `ST_ADD1:      word = aluWord(`ALU_ADD, `SRCA_A, `SRCB_B) | mAluOut;
            `ST_AND0:      word = aluWord(`ALU_AND, `SRCA_A, `SRCB_B);
            `ST_AND1:      word = aluWord(`ALU_AND, `SRCA_A, `SRCB_B) | mAluOut;
            `ST_SUB0:      word = aluWord(`ALU_SUB, `SRCA_A, `SRCB_B);
            `ST_SUB1:      word = aluWord(`ALU_SUB, `SRCA_A, `SRCB_B) | mAluOut;
            `ST_ARITH_END: word = wb(`DST_RD, `M2R_ALUOUT);
            `ST_ADDIU0:    word = aluWord(`ALU_ADD, `SRCA_A, `SRCB_IMM);
            `ST_ADDIU1:    word = aluWord(`ALU_ADD, `SRCA_A, `SRCB_IMM) | mAluOut;
            `ST_ADDIU_END: word = wb(`DST_RT, `M2R_ALUOUT);
            // Compare result comes from the LT path
            `ST_SLT0:      word = aluWord(`ALU_CMP, `SRCA_A, `SRCB_B);
            `ST_SLT1:      word = wb(`DST_RD, `M2R_LT);
            `ST_SLTI0:     word = aluWord(`ALU_CMP, `SRCA_A, `SRCB_IMM);
            `ST_SLTI1:     word = wb(`DST_RT, `M2R_LT);
            `ST_MFHI:      word = wb(`DST_RD, `M2R_HI);
            `ST_MFLO:      word = wb(`DST_RD, `M2R_LO);
            // rs passed through and latched for the shared PC write
            `ST_JR:        word = aluWord(`ALU_PASS, `SRCA_A, `SRCB_B) | pcSel(`PCSRC_ALU)
                                  | mAluOut;
            // Flags settle here, no write yet
            `ST_BR_EQ:     word = aluWord(`ALU_SUB, `SRCA_A, `SRCB_B) | pcSel(`PCSRC_ALUOUT);
            `ST_BR_GT:     word = aluWord(`ALU_CMP, `SRCA_A, `SRCB_B) | pcSel(`PCSRC_ALUOUT);
            `ST_PC_END:    word = pcSel(`PCSRC_ALUOUT) | mPcWrite;
            `ST_JUMP:      word = pcSel(`PCSRC_JUMP) | mPcWrite;
            default:       word = '0;
        endcase
    end

    // Fields onto the ports
    assign aluOp      = word[ctrlPkg::aluOpLsb +: 3];
    assign aluSrcA    = word[ctrlPkg::aluSrcALsb +: 2];
    assign aluSrcB    = word[ctrlPkg::aluSrcBLsb +: 3];
    assign pcSrc      = word[ctrlPkg::pcSrcLsb +: 3];
    assign regDst     = word[ctrlPkg::regDstLsb +: 2];
    assign memToReg   = word[ctrlPkg::memToRegLsb +: 3];
    assign regWrite   = word[ctrlPkg::regWriteBit];
    assign pcWrite    = word[ctrlPkg::pcWriteBit];
    assign irWrite    = word[ctrlPkg::irWriteBit];
    assign aWrite     = word[ctrlPkg::aWriteBit];
    assign bWrite     = word[ctrlPkg::bWriteBit];
    assign aluOutCtrl = word[ctrlPkg::aluOutBit];
    assign resetOut   = word[ctrlPkg::resetOutBit];

endmodule

// ==== hw/controlUnit.sv ====
module controlUnit (
    input  logic               clk,
    input  logic               reset_in,
    input  isaPkg::instrWord_t instr,
    input  logic               zero,
    input  logic               greater,
    output logic [2:0]         aluOp,
    output logic [1:0]         aluSrcA,
    output logic [2:0]         aluSrcB,
    output logic [2:0]         pcSrc,
    output logic [1:0]         regDst,
    output logic [2:0]         memToReg,
    output logic               regWrite,
    output logic               pcWrite,
    output logic               irWrite,
    output logic               aWrite,
    output logic               bWrite,
    output logic               aluOutCtrl,
    output logic               resetOut
);

    // Decoder to FSM
    isaPkg::opClass_t    opClass;
    logic                branchOnTrue;
    // FSM and wait timer handshake
    logic                timerLoad;
    logic [1:0]          timerLen;
    logic                timerDone;
    // FSM to output table
    ctrlPkg::stateCode_t stateCode;

    instrDecoder uDecoder (
        .instr        (instr),
        .opClass      (opClass),
        .branchOnTrue (branchOnTrue)
    );

    waitTimer uTimer (
        .clk       (clk),
        .reset_in  (reset_in),
        .timerLoad (timerLoad),
        .timerLen  (timerLen),
        .timerDone (timerDone)
    );

    mainFsm uFsm (
        .clk          (clk),
        .reset_in     (reset_in),
        .opClass      (opClass),
        .branchOnTrue (branchOnTrue),
        .zero         (zero),
        .greater      (greater),
        .timerDone    (timerDone),
        .stateCode    (stateCode),
        .timerLoad    (timerLoad),
        .timerLen     (timerLen)
    );

    controlRom uRom (
        .stateCode  (stateCode),
        .aluOp      (aluOp),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .pcSrc      (pcSrc),
        .regDst     (regDst),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .aWrite     (aWrite),
        .bWrite     (bWrite),
        .aluOutCtrl (aluOutCtrl),
        .resetOut   (resetOut)
    );

endmodule

// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [6:0] stateCode_t;

    // Packed control word, bits 24:23 spare and always zero
    typedef logic [24:0] ctrlWord_t;

    // Single-bit strobes
    localparam int resetOutBit = 0;
    localparam int aluOutBit   = 1;
    localparam int bWriteBit   = 2;
    localparam int aWriteBit   = 3;
    localparam int irWriteBit  = 4;
    localparam int pcWriteBit  = 5;
    localparam int regWriteBit = 6;

    // Multi-bit selectors, low bit of each field
    localparam int pcSrcLsb    = 7;
    localparam int aluSrcBLsb  = 10;
    localparam int aluSrcALsb  = 13;
    localparam int memToRegLsb = 15;
    localparam int regDstLsb   = 18;
    localparam int aluOpLsb    = 20;

endpackage

// ==== hw/ctrl_defines.svh ====
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Primary opcodes
`define OP_RTYPE     6'h00
`define OP_J         6'h02
`define OP_BEQ       6'h04
`define OP_BNE       6'h05
`define OP_BLE       6'h06
`define OP_BGT       6'h07
`define OP_ADDIU     6'h09
`define OP_SLTI      6'h0a

// Funct codes under OP_RTYPE
`define FN_JR        6'h08
`define FN_MFHI      6'h10
`define FN_MFLO      6'h12
`define FN_ADD       6'h20
`define FN_SUB       6'h22
`define FN_AND       6'h24
`define FN_SLT       6'h2a

// FSM state codes
`define ST_RESET     7'd0
`define ST_FETCH0    7'd1
`define ST_FETCH1    7'd2
`define ST_DECODE0   7'd3
`define ST_DECODE1   7'd4
`define ST_ADD0      7'd5
`define ST_ADD1      7'd6
// Shared writeback for ADD, AND and SUB
`define ST_ARITH_END 7'd7
`define ST_ADDIU0    7'd8
`define ST_ADDIU1    7'd9
`define ST_ADDIU_END 7'd10
`define ST_AND0      7'd11
`define ST_AND1      7'd12
`define ST_SUB0      7'd13
`define ST_SUB1      7'd14
`define ST_MFHI      7'd15
`define ST_MFLO      7'd16
`define ST_JR        7'd17
`define ST_BR_EQ     7'd19
`define ST_BR_GT     7'd20
// PC write that closes JR and taken branches
`define ST_PC_END    7'd21
`define ST_SLT0      7'd29
`define ST_SLT1      7'd30
`define ST_SLTI0     7'd31
`define ST_SLTI1     7'd32
`define ST_JUMP      7'd33

// Cycles spent in FETCH0 and DECODE1
`define FETCH_WAIT   2'd3
`define DECODE_WAIT  2'd3

// Execution path classes
`define CLS_UNKNOWN  4'd0
`define CLS_ADD      4'd1
`define CLS_AND      4'd2
`define CLS_SUB      4'd3
`define CLS_SLT      4'd4
`define CLS_MFHI     4'd5
`define CLS_MFLO     4'd6
`define CLS_JR       4'd7
`define CLS_ADDIU    4'd8
`define CLS_SLTI     4'd9
`define CLS_BR_EQ    4'd10
`define CLS_BR_GT    4'd11
`define CLS_JUMP     4'd12

// ALU operation
`define ALU_PASS     3'd0
`define ALU_ADD      3'd1
`define ALU_SUB      3'd2
`define ALU_AND      3'd3
`define ALU_CMP      3'd7

// ALU operand selects
`define SRCA_PC      2'd0
`define SRCA_A       2'd2
`define SRCB_B       3'd0
`define SRCB_FOUR    3'd1
`define SRCB_IMM     3'd3

// PC source
`define PCSRC_JUMP   3'd0
`define PCSRC_ALU    3'd2
`define PCSRC_ALUOUT 3'd4

// Register file destination and write data
`define DST_RT       2'd0
`define DST_RD       2'd1
`define DST_SP       2'd3
`define M2R_LO       3'd1
`define M2R_HI       3'd2
`define M2R_SPINIT   3'd4
`define M2R_ALUOUT   3'd6
`define M2R_LT       3'd7

`endif

// ==== hw/instrDecoder.sv ====
`include "ctrl_defines.svh"

module instrDecoder (
    input  isaPkg::instrWord_t instr,
    output isaPkg::opClass_t   opClass,
    output logic               branchOnTrue
);

    always_comb begin
        opClass      = `CLS_UNKNOWN;
        branchOnTrue = 1'b0;
        // Opcode sits in the same bits in both views
        if (instr.r.opcode == `OP_RTYPE) begin
            // R type, the path comes from funct
            case (instr.r.funct)
                `FN_ADD:  opClass = `CLS_ADD;
                `FN_AND:  opClass = `CLS_AND;
                `FN_SUB:  opClass = `CLS_SUB;
                `FN_SLT:  opClass = `CLS_SLT;
                `FN_MFHI: opClass = `CLS_MFHI;
                `FN_MFLO: opClass = `CLS_MFLO;
                `FN_JR:   opClass = `CLS_JR;
                default:  opClass = `CLS_UNKNOWN;
            endcase
        end else begin
            case (instr.i.opcode)
                `OP_ADDIU: opClass = `CLS_ADDIU;
                `OP_SLTI:  opClass = `CLS_SLTI;
                `OP_J:     opClass = `CLS_JUMP;
                // Equal pair, taken on zero set
                `OP_BEQ: begin
                    opClass      = `CLS_BR_EQ;
                    branchOnTrue = 1'b1;
                end
                // Taken on zero clear
                `OP_BNE: begin
                    opClass      = `CLS_BR_EQ;
                    branchOnTrue = 1'b0;
                end
                // Greater pair, BLE wants the flag low
                `OP_BLE: begin
                    opClass      = `CLS_BR_GT;
                    branchOnTrue = 1'b0;
                end
                `OP_BGT: begin
                    opClass      = `CLS_BR_GT;
                    branchOnTrue = 1'b1;
                end
                default: opClass = `CLS_UNKNOWN;
            endcase
        end
    end

endmodule

// ==== hw/isaPkg.sv ====
package isaPkg;

    // R format: register to register
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat_t;

    // I format: immediate and branch offset
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat_t;

    // One instruction word, two views of it
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
    } instrWord_t;

    // Execution path code, values in CLS_* macros
    typedef logic [3:0] opClass_t;

endpackage

// ==== hw/mainFsm.sv ====
`include "ctrl_defines.svh"

module mainFsm (
    input  logic                clk,
    input  logic                reset_in,
    input  isaPkg::opClass_t    opClass,
    input  logic                branchOnTrue,
    input  logic                zero,
    input  logic                greater,
    input  logic                timerDone,
    output ctrlPkg::stateCode_t stateCode,
    output logic                timerLoad,
    output logic [1:0]          timerLen
);

    ctrlPkg::stateCode_t nextState;

    // Wait length for whichever stretched state is active
    assign timerLen = (stateCode == `ST_DECODE1) ? `DECODE_WAIT : `FETCH_WAIT;

    always_comb begin
        nextState = stateCode;
        case (stateCode)
            `ST_RESET:   nextState = `ST_FETCH0;
            // Memory read wait
            `ST_FETCH0: begin
                if (timerDone) begin
                    nextState = `ST_FETCH1;
                end
            end
            `ST_FETCH1:  nextState = `ST_DECODE0;
            `ST_DECODE0: nextState = `ST_DECODE1;
            // Register read wait, then dispatch
            `ST_DECODE1: begin
                if (timerDone) begin
                    case (opClass)
                        `CLS_ADD:   nextState = `ST_ADD0;
                        `CLS_AND:   nextState = `ST_AND0;
                        `CLS_SUB:   nextState = `ST_SUB0;
                        `CLS_SLT:   nextState = `ST_SLT0;
                        `CLS_MFHI:  nextState = `ST_MFHI;
                        `CLS_MFLO:  nextState = `ST_MFLO;
                        `CLS_JR:    nextState = `ST_JR;
                        `CLS_ADDIU: nextState = `ST_ADDIU0;
                        `CLS_SLTI:  nextState = `ST_SLTI0;
                        `CLS_BR_EQ: nextState = `ST_BR_EQ;
                        `CLS_BR_GT: nextState = `ST_BR_GT;
                        `CLS_JUMP:  nextState = `ST_JUMP;
                        // Unknown instruction, straight back to fetch
                        default:    nextState = `ST_FETCH0;
                    endcase
                end
            end
            // Two ALU cycles, then a common writeback
            `ST_ADD0:    nextState = `ST_ADD1;
            `ST_AND0:    nextState = `ST_AND1;
            `ST_SUB0:    nextState = `ST_SUB1;
            `ST_ADD1, `ST_AND1, `ST_SUB1: nextState = `ST_ARITH_END;
            `ST_ADDIU0:  nextState = `ST_ADDIU1;
            `ST_ADDIU1:  nextState = `ST_ADDIU_END;
            `ST_SLT0:    nextState = `ST_SLT1;
            `ST_SLTI0:   nextState = `ST_SLTI1;
            `ST_JR:      nextState = `ST_PC_END;
            // Taken when the flag matches the wanted sense
            `ST_BR_EQ:   nextState = (zero == branchOnTrue) ? `ST_PC_END : `ST_FETCH0;
            `ST_BR_GT:   nextState = (greater == branchOnTrue) ? `ST_PC_END : `ST_FETCH0;
            // Last cycle of every path
            `ST_ARITH_END, `ST_ADDIU_END, `ST_SLT1, `ST_SLTI1,
            `ST_MFHI, `ST_MFLO, `ST_JUMP, `ST_PC_END: nextState = `ST_FETCH0;
            default:     nextState = `ST_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_in) begin
            stateCode <= `ST_RESET;
            timerLoad <= 1'b0;
        end else begin
            stateCode <= nextState;
            // Pulse in the first cycle of a stretched state
            timerLoad <= (nextState != stateCode) &&
                         ((nextState == `ST_FETCH0) || (nextState == `ST_DECODE1));
        end
    end

endmodule

// ==== hw/waitTimer.sv ====
module waitTimer (
    input  logic       clk,
    input  logic       reset_in,
    input  logic       timerLoad,
    input  logic [1:0] timerLen,
    output logic       timerDone
);

    logic [1:0] count;
    logic       armed;
    logic [1:0] remaining;

    // Cycles left after this one, load cycle counts as the first
    assign remaining = timerLoad ? (timerLen - 2'd1) : count;

    // Only a loaded wait may finish
    assign timerDone = (timerLoad | armed) & (remaining == 2'd0);

    always_ff @(posedge clk) begin
        if (reset_in) begin
            count <= 2'd0;
            armed <= 1'b0;
        end else if (timerLoad | armed) begin
            // Stays armed until the count runs out
            armed <= (remaining != 2'd0);
            if (remaining != 2'd0) begin
                count <= remaining - 2'd1;
            end
        end
    end

endmodule

// ==== tests/controlUnitTb.sv ====
`include "ctrl_defines.svh"

module controlUnitTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int numTests      = 45;
    localparam int timeoutCycles = numTests * 16 + 50;

    // Expected outcome of one instruction
    typedef struct {
        int                 len;
        ctrlPkg::ctrlWord_t firstWord;
        ctrlPkg::ctrlWord_t firstMask;
        ctrlPkg::ctrlWord_t lastWord;
        ctrlPkg::ctrlWord_t lastMask;
        bit                 pcWritten;
        bit                 regWritten;
    } expect_t;

    logic clk;
    logic reset_in;
    isaPkg::instrWord_t instr;
    logic zero;
    logic greater;
    logic [2:0] aluOp;
    logic [1:0] aluSrcA;
    logic [2:0] aluSrcB;
    logic [2:0] pcSrc;
    logic [1:0] regDst;
    logic [2:0] memToReg;
    logic regWrite;
    logic pcWrite;
    logic irWrite;
    logic aWrite;
    logic bWrite;
    logic aluOutCtrl;
    logic resetOut;

    ctrlPkg::ctrlWord_t observed;
    ctrlPkg::ctrlWord_t trace[$];
    int unsigned lcgState = 7;
    int errorCount = 0;
    int checkTotal = 0;
    int doneCount = 0;
    int cycleCount = 0;
    int testErrBase = 0;
    bit testActive = 1'b0;
    // Instruction currently in flight
    isaPkg::instrWord_t curInstr;
    logic curZero;
    logic curGreater;
    string curName = "none";

    controlUnit u_dut (
        .clk        (clk),
        .reset_in   (reset_in),
        .instr      (instr),
        .zero       (zero),
        .greater    (greater),
        .aluOp      (aluOp),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .pcSrc      (pcSrc),
        .regDst     (regDst),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .aWrite     (aWrite),
        .bWrite     (bWrite),
        .aluOutCtrl (aluOutCtrl),
        .resetOut   (resetOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Observed ports as one control word
    always_comb begin
        observed = '0;
        observed[ctrlPkg::aluOpLsb +: 3]    = aluOp;
        observed[ctrlPkg::aluSrcALsb +: 2]  = aluSrcA;
        observed[ctrlPkg::aluSrcBLsb +: 3]  = aluSrcB;
        observed[ctrlPkg::pcSrcLsb +: 3]    = pcSrc;
        observed[ctrlPkg::regDstLsb +: 2]   = regDst;
        observed[ctrlPkg::memToRegLsb +: 3] = memToReg;
        observed[ctrlPkg::regWriteBit]      = regWrite;
        observed[ctrlPkg::pcWriteBit]       = pcWrite;
        observed[ctrlPkg::irWriteBit]       = irWrite;
        observed[ctrlPkg::aWriteBit]        = aWrite;
        observed[ctrlPkg::bWriteBit]        = bWrite;
        observed[ctrlPkg::aluOutBit]        = aluOutCtrl;
        observed[ctrlPkg::resetOutBit]      = resetOut;
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    // Value placed at a field offset
    function automatic ctrlPkg::ctrlWord_t put(input int lsb, input int value);
        ctrlPkg::ctrlWord_t w;
        w = ctrlPkg::ctrlWord_t'(value);
        return w << lsb;
    endfunction

    function automatic ctrlPkg::ctrlWord_t aluFields(input int op, input int srcA);
        return put(ctrlPkg::aluOpLsb, op) | put(ctrlPkg::aluSrcALsb, srcA);
    endfunction

    function automatic ctrlPkg::ctrlWord_t writeback(input int dst, input int m2r);
        return put(ctrlPkg::regDstLsb, dst) | put(ctrlPkg::memToRegLsb, m2r)
               | put(ctrlPkg::regWriteBit, 1);
    endfunction

    // Expected path from the instruction rules
    function automatic expect_t refModel(input isaPkg::instrWord_t i, input logic z,
                                         input logic g);
        expect_t e;
        bit taken;
        e.len = 0;
        e.firstWord = '0;
        e.firstMask = aluFields(7, 3);
        e.lastWord = '0;
        e.lastMask = put(ctrlPkg::regDstLsb, 3) | put(ctrlPkg::memToRegLsb, 7)
                     | put(ctrlPkg::aluOpLsb, 7) | put(ctrlPkg::pcSrcLsb, 7)
                     | put(ctrlPkg::regWriteBit, 1) | put(ctrlPkg::pcWriteBit, 1);
        e.pcWritten = 1'b0;
        e.regWritten = 1'b0;
        taken = 1'b0;
        case (i.r.opcode)
            `OP_RTYPE: begin
                case (i.r.funct)
                    `FN_ADD: begin
                        e.len = 3;
                        e.firstWord = aluFields(1, 2);
                    end
                    `FN_AND: begin
                        e.len = 3;
                        e.firstWord = aluFields(3, 2);
                    end
                    `FN_SUB: begin
                        e.len = 3;
                        e.firstWord = aluFields(2, 2);
                    end
                    `FN_SLT: begin
                        e.len = 2;
                        e.firstWord = aluFields(7, 2);
                    end
                    `FN_MFHI, `FN_MFLO: begin
                        e.len = 1;
                        e.firstMask = '0;
                    end
                    // rs through the ALU, then the PC write
                    `FN_JR: begin
                        e.len = 2;
                        e.firstMask = put(ctrlPkg::pcSrcLsb, 7) | put(ctrlPkg::pcWriteBit, 1);
                        e.firstWord = put(ctrlPkg::pcSrcLsb, 2);
                        e.lastWord = put(ctrlPkg::pcSrcLsb, 4) | put(ctrlPkg::pcWriteBit, 1);
                        e.pcWritten = 1'b1;
                    end
                    default: e.len = 0;
                endcase
                // rd destination for every R writer
                case (i.r.funct)
                    `FN_ADD, `FN_AND, `FN_SUB: e.lastWord = writeback(1, 6);
                    `FN_SLT:  e.lastWord = writeback(1, 7);
                    `FN_MFHI: e.lastWord = writeback(1, 2);
                    `FN_MFLO: e.lastWord = writeback(1, 1);
                    default: ;
                endcase
                e.regWritten = (e.len > 0) && (i.r.funct != `FN_JR);
            end
            `OP_ADDIU: begin
                e.len = 3;
                e.firstWord = aluFields(1, 2);
                e.lastWord = writeback(0, 6);
                e.regWritten = 1'b1;
            end
            `OP_SLTI: begin
                e.len = 2;
                e.firstWord = aluFields(7, 2);
                e.lastWord = writeback(0, 7);
                e.regWritten = 1'b1;
            end
            `OP_J: begin
                e.len = 1;
                e.firstMask = e.lastMask;
                e.firstWord = put(ctrlPkg::pcWriteBit, 1);
                e.lastWord = e.firstWord;
                e.pcWritten = 1'b1;
            end
            `OP_BEQ, `OP_BNE, `OP_BLE, `OP_BGT: begin
                case (i.i.opcode)
                    `OP_BEQ: taken = z;
                    `OP_BNE: taken = !z;
                    `OP_BLE: taken = !g;
                    default: taken = g;
                endcase
                // Equal pair subtracts, greater pair compares
                e.firstMask = put(ctrlPkg::aluOpLsb, 7) | put(ctrlPkg::pcWriteBit, 1);
                e.firstWord = put(ctrlPkg::aluOpLsb,
                                  (i.i.opcode == `OP_BEQ || i.i.opcode == `OP_BNE) ? 2 : 7);
                e.len = taken ? 2 : 1;
                e.lastWord = taken ? (put(ctrlPkg::pcSrcLsb, 4) | put(ctrlPkg::pcWriteBit, 1))
                                   : (e.firstWord | put(ctrlPkg::pcSrcLsb, 4));
                e.pcWritten = taken;
            end
            default: e.len = 0;
        endcase
        return e;
    endfunction

    function automatic string kindName(input int k);
        string names[15] = '{"add", "and", "sub", "slt", "mfhi", "mflo", "jr", "addiu",
                             "slti", "beq", "bne", "ble", "bgt", "j", "unknown"};
        return names[k];
    endfunction

    function automatic isaPkg::instrWord_t makeInstr(input int k);
        isaPkg::instrWord_t w;
        logic [5:0] fn[7] = '{`FN_ADD, `FN_AND, `FN_SUB, `FN_SLT, `FN_MFHI, `FN_MFLO, `FN_JR};
        logic [5:0] op[8] = '{`OP_ADDIU, `OP_SLTI, `OP_BEQ, `OP_BNE, `OP_BLE, `OP_BGT,
                              `OP_J, 6'h3f};
        w = '0;
        w.r.rs = 5'(nextRand());
        w.r.rt = 5'(nextRand());
        if (k < 7) begin
            w.r.opcode = `OP_RTYPE;
            w.r.rd = 5'(nextRand());
            w.r.funct = fn[k];
        end else begin
            w.i.opcode = op[k - 7];
            w.i.imm = 16'(nextRand());
        end
        return w;
    endfunction

    task automatic checkWord(input string name, input string what,
                             input ctrlPkg::ctrlWord_t exp, input ctrlPkg::ctrlWord_t act);
        checkTotal++;
        if (exp !== act) begin
            errorCount++;
            $display("FAIL %s expected %h actual %h (%s)", name, exp, act, what);
        end
    endtask

    task automatic checkCount(input string name, input string what, input int exp,
                              input int act);
        checkTotal++;
        if (exp != act) begin
            errorCount++;
            $display("FAIL %s expected %0d actual %0d (%s)", name, exp, act, what);
        end
    endtask

    task automatic checkFlag(input string name, input string what, input bit exp,
                             input bit act);
        checkTotal++;
        if (exp != act) begin
            errorCount++;
            $display("FAIL %s expected %0b actual %0b (%s)", name, exp, act, what);
        end
    endtask

    // One fetch-to-fetch trace against the reference
    task automatic finishTest();
        expect_t e;
        bit pcSeen;
        bit regSeen;
        ctrlPkg::ctrlWord_t strobeMask;
        ctrlPkg::ctrlWord_t fetchWord;
        ctrlPkg::ctrlWord_t readWord;
        e = refModel(curInstr, curZero, curGreater);
        pcSeen = 1'b0;
        regSeen = 1'b0;
        // All single-bit strobes
        strobeMask = put(ctrlPkg::resetOutBit, 7'h7f);
        fetchWord = put(ctrlPkg::irWriteBit, 1) | put(ctrlPkg::pcWriteBit, 1);
        readWord = put(ctrlPkg::aWriteBit, 1) | put(ctrlPkg::bWriteBit, 1)
                   | put(ctrlPkg::aluOutBit, 1);
        checkCount(curName, "period", e.len + 8, trace.size());
        // Instruction latch, then register read wait
        if (trace.size() >= 5) begin
            checkWord(curName, "fetch strobes", fetchWord, trace[0] & strobeMask);
            for (int n = 2; n < 5; n++) begin
                checkWord(curName, "register read strobes", readWord, trace[n] & strobeMask);
            end
        end
        if (trace.size() == e.len + 8 && e.len > 0) begin
            if (e.firstMask != '0) begin
                checkWord(curName, "first exec", e.firstWord, trace[5] & e.firstMask);
            end
            checkWord(curName, "last exec", e.lastWord, trace[4 + e.len] & e.lastMask);
        end
        // Everything after the instruction latch
        for (int n = 1; n < trace.size(); n++) begin
            pcSeen |= trace[n][ctrlPkg::pcWriteBit];
            regSeen |= trace[n][ctrlPkg::regWriteBit];
        end
        checkFlag(curName, "pc written", e.pcWritten, pcSeen);
        checkFlag(curName, "reg written", e.regWritten, regSeen);
        $display("test %0d %s %s", doneCount + 1, curName,
                 (errorCount == testErrBase) ? "ok" : "failed");
        doneCount++;
    endtask

    // Monitor, one trace per FETCH1
    always @(negedge clk) begin
        if (!reset_in) begin
            if (irWrite) begin
                if (testActive) begin
                    finishTest();
                end
                trace.delete();
                testActive = 1'b1;
                testErrBase = errorCount;
            end
            if (testActive) begin
                trace.push_back(observed);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, only %0d tests finished", cycleCount, doneCount);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic checkResetPhase();
        ctrlPkg::ctrlWord_t resetWord;
        int n;
        int base;
        base = errorCount;
        resetWord = writeback(3, 4) | put(ctrlPkg::resetOutBit, 1);
        repeat (2) begin
            @(negedge clk);
            checkWord("reset", "held", resetWord, observed);
        end
        @(posedge clk);
        #2 reset_in = 1'b0;
        @(negedge clk);
        checkWord("reset", "after release", resetWord, observed);
        n = 0;
        while (irWrite !== 1'b1) begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        checkCount("reset", "cycles to irWrite", 4, n);
        $display("test 0 reset %s", (errorCount == base) ? "ok" : "failed");
    endtask

    initial begin
        int kind;
        reset_in = 1'b1;
        instr = '0;
        zero = 1'b0;
        greater = 1'b0;
        curInstr = '0;
        curZero = 1'b0;
        curGreater = 1'b0;
        checkResetPhase();
        for (int t = 0; t < numTests; t++) begin
            // Reset phase already stopped in FETCH1
            if (t != 0) begin
                do @(negedge clk); while (irWrite !== 1'b1);
            end
            @(posedge clk);
            #2;
            if (t < 15) begin
                kind = t;
            end else if (nextRand() % 2 == 0) begin
                kind = 9 + int'(nextRand() % 4);
            end else begin
                kind = int'(nextRand() % 15);
            end
            curInstr = makeInstr(kind);
            curZero = 1'(nextRand());
            curGreater = 1'(nextRand());
            curName = kindName(kind);
            instr = curInstr;
            zero = curZero;
            greater = curGreater;
        end
        wait (doneCount == numTests);
        @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors", doneCount + 1, checkTotal, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
